/* hw/core_cfg.svh */
//////////////////////////////
// bridge write map and timing constants for the shell
// RESET_CYCLES is short so that simulation stays fast;
// hardware builds want a much longer soft reset
//////////////////////////////

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// bridge write addresses of the settings registers
`define ADDR_RESET          32'h0000_0050
`define ADDR_OVERSCAN       32'h0000_0200
`define ADDR_EDGE_MASK      32'h0000_0204
`define ADDR_EXTRA_SPRITES  32'h0000_0208
`define ADDR_PALETTE        32'h0000_020C
`define ADDR_MULTITAP       32'h0000_0300
`define ADDR_PAD_SWAP       32'h0000_0310

// soft reset length in clk_74a cycles
`define RESET_CYCLES        256

// count loaded when the core's horizontal sync rises
`define HS_DELAY_CYCLES     7

// bit of the slot word that carries hide_overscan
`define SLOT_OVERSCAN_BIT   13

// save RAM size reported to the host
`define SAVE_SIZE_BYTES     32'h0004_0000

// data-table entry that holds the save size
`define DATATABLE_SAVE_ADDR 3

`endif

/* hw/settings_pkg.sv */
//////////////////////////////
// field types of the bridge and the settings registers
// widths follow the host bridge and data-table layout
//////////////////////////////

package settings_pkg;

  //////////////////////////////
  // bridge bus
  //////////////////////////////

  // byte address of a bridge access
  typedef logic [31:0] bridge_addr_t;

  // one bridge data word, also the data-table word
  typedef logic [31:0] bridge_data_t;

  //////////////////////////////
  // settings fields
  //////////////////////////////

  // edge masking mode, passed through to the core untouched
  typedef logic [1:0] edge_mask_t;

  // palette index, up to eight palettes
  typedef logic [2:0] palette_sel_t;

  //////////////////////////////
  // data table
  //////////////////////////////

  // data-table index, 1024 entries
  typedef logic [9:0] datatable_addr_t;

endpackage

/* hw/media_pkg.sv */
//////////////////////////////
// controller and pixel word layouts
// pad_keys_t follows the host key bitmap, bit 0 is dpad up
//////////////////////////////

package media_pkg;

  // host key bitmap, msb first
  typedef struct packed {
    logic start;
    logic select;
    logic trig_r3;
    logic trig_l3;
    logic trig_r2;
    logic trig_l2;
    logic trig_r1;
    logic trig_l1;
    logic y;
    logic x;
    logic b;
    logic a;
    logic right;
    logic left;
    logic down;
    logic up;
  } pad_keys_t;

  // console pad word, bit 0 is A
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } console_pad_t;

  // one pixel, red in the high byte
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

endpackage

/* hw/bridge_regs.sv */
//////////////////////////////
// host bridge write decoder and settings registers
// only full-address matches are decoded, reads are not served
// the data-table entry is rewritten every cycle
//////////////////////////////

`timescale 1ns/1ns

`include "core_cfg.svh"

module bridge_regs (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,

  // host writes
  input  settings_pkg::bridge_addr_t    bridge_addr,
  input  logic                          bridge_wr,
  input  settings_pkg::bridge_data_t    bridge_wr_data,

  // data slot strobes and save flag
  input  logic                          dataslot_requestwrite,
  input  logic                          dataslot_allcomplete,
  input  logic                          has_save,

  // settings towards the core
  output logic                          hide_overscan,
  output settings_pkg::edge_mask_t      mask_vid_edges,
  output logic                          allow_extra_sprites,
  output settings_pkg::palette_sel_t    selected_palette,
  output logic                          multitap_enabled,
  output logic                          pad_swap,
  output logic                          external_reset,
  output logic                          ioctl_download,

  // data-table write port
  output settings_pkg::datatable_addr_t datatable_addr,
  output logic                          datatable_wren,
  output settings_pkg::bridge_data_t    datatable_data
);

  import settings_pkg::*;

  localparam int RST_CNT_W = $clog2(`RESET_CYCLES + 1);

  logic [RST_CNT_W-1:0] reset_cnt;

  //////////////////////////////
  // settings registers
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
      pad_swap            <= 1'b0;
    end else if (bridge_wr) begin
      // each field takes the low bits of the write data
      case (bridge_addr)
        `ADDR_OVERSCAN:      hide_overscan       <= bridge_wr_data[0];
        `ADDR_EDGE_MASK:     mask_vid_edges      <= edge_mask_t'(bridge_wr_data[1:0]);
        `ADDR_EXTRA_SPRITES: allow_extra_sprites <= bridge_wr_data[0];
        `ADDR_PALETTE:       selected_palette    <= palette_sel_t'(bridge_wr_data[2:0]);
        `ADDR_MULTITAP:      multitap_enabled    <= bridge_wr_data[0];
        `ADDR_PAD_SWAP:      pad_swap            <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // soft reset counter
  //////////////////////////////

  // a new write restarts the count
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (bridge_wr && (bridge_addr == `ADDR_RESET)) begin
      reset_cnt <= RST_CNT_W'(`RESET_CYCLES);
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 1'b1;
    end
  end

  assign external_reset = (reset_cnt != '0);

  //////////////////////////////
  // download level
  //////////////////////////////

  // set wins when both strobes meet
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ioctl_download <= 1'b0;
    end else if (dataslot_requestwrite) begin
      ioctl_download <= 1'b1;
    end else if (dataslot_allcomplete) begin
      ioctl_download <= 1'b0;
    end
  end

  //////////////////////////////
  // data-table writer
  //////////////////////////////

  // save size entry, zero when the cart has no save RAM
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
    end else begin
      datatable_addr <= datatable_addr_t'(`DATATABLE_SAVE_ADDR);
      datatable_wren <= 1'b1;
      datatable_data <= has_save ? bridge_data_t'(`SAVE_SIZE_BYTES) : '0;
    end
  end

endmodule

/* hw/pad_mapper.sv */
//////////////////////////////
// host key bitmaps to console pad words
// one cycle of latency, swap only affects pad 1
//////////////////////////////

`timescale 1ns/1ns

module pad_mapper (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  logic                   pad_swap,
  input  media_pkg::pad_keys_t   cont1_key,
  input  media_pkg::pad_keys_t   cont2_key,
  input  media_pkg::pad_keys_t   cont3_key,
  input  media_pkg::pad_keys_t   cont4_key,
  output media_pkg::console_pad_t pad1,
  output media_pkg::console_pad_t pad2,
  output media_pkg::console_pad_t pad3,
  output media_pkg::console_pad_t pad4
);

  import media_pkg::*;

  // pick the eight console buttons, with the optional Y/B swap
  function automatic console_pad_t map_keys(input pad_keys_t keys, input logic swap);
    console_pad_t pad;
    pad.a      = swap ? keys.b : keys.a;
    pad.b      = swap ? keys.y : keys.b;
    pad.select = keys.select;
    pad.start  = keys.start;
    pad.up     = keys.up;
    pad.down   = keys.down;
    pad.left   = keys.left;
    pad.right  = keys.right;
    return pad;
  endfunction

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pad1 <= '0;
      pad2 <= '0;
      pad3 <= '0;
      pad4 <= '0;
    end else begin
      pad1 <= map_keys(cont1_key, pad_swap);
      // other pads always map directly
      pad2 <= map_keys(cont2_key, 1'b0);
      pad3 <= map_keys(cont3_key, 1'b0);
      pad4 <= map_keys(cont4_key, 1'b0);
    end
  end

endmodule

/* hw/video_conditioner.sv */
//////////////////////////////
// scaler-facing video from the core's blanking and syncs
// syncs become single-cycle pulses on their rising edge;
// hsync is delayed so it never lands on vsync
//////////////////////////////

`timescale 1ns/1ns

`include "core_cfg.svh"

module video_conditioner (
  input  logic            clk_74a,
  input  logic            pll_core_locked,
  input  logic            hide_overscan,
  input  logic            h_blank,
  input  logic            v_blank,
  input  logic            core_hs,
  input  logic            core_vs,
  input  media_pkg::rgb_t core_rgb,
  output logic            video_de,
  output logic            video_hs,
  output logic            video_vs,
  output media_pkg::rgb_t video_rgb
);

  import media_pkg::*;

  localparam int HS_CNT_W = $clog2(`HS_DELAY_CYCLES + 1);

  logic                de;
  logic                de_prev;
  logic                hs_prev;
  logic                vs_prev;
  logic [HS_CNT_W-1:0] hs_cnt;
  rgb_t                slot_word;

  assign de = ~(h_blank | v_blank);

  // slot word, sent once at the end of each active line
  always_comb begin
    slot_word = '0;
    slot_word[`SLOT_OVERSCAN_BIT] = hide_overscan;
  end

  //////////////////////////////
  // data enable and pixels
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
    end else begin
      video_de <= de;
      de_prev  <= de;
      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        // first blank cycle after the line
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  //////////////////////////////
  // sync pulses
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_vs <= 1'b0;
      video_hs <= 1'b0;
      vs_prev  <= 1'b0;
      hs_prev  <= 1'b0;
      hs_cnt   <= '0;
    end else begin
      vs_prev  <= core_vs;
      hs_prev  <= core_hs;
      video_vs <= core_vs & ~vs_prev;
      // pulse on the last step of the delay count
      video_hs <= (hs_cnt == HS_CNT_W'(2));
      if (core_hs && !hs_prev) begin
        hs_cnt <= HS_CNT_W'(`HS_DELAY_CYCLES);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

endmodule

/* hw/nes_shell_top.sv */
//////////////////////////////
// shell logic around the emulated console, all on clk_74a
// settings, reset and pad words leave for an external core
//////////////////////////////

`timescale 1ns/1ns

module nes_shell_top (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,

  // host bridge and data slots
  input  settings_pkg::bridge_addr_t    bridge_addr,
  input  logic                          bridge_wr,
  input  settings_pkg::bridge_data_t    bridge_wr_data,
  input  logic                          dataslot_requestwrite,
  input  logic                          dataslot_allcomplete,
  input  logic                          has_save,

  // controllers
  input  media_pkg::pad_keys_t          cont1_key,
  input  media_pkg::pad_keys_t          cont2_key,
  input  media_pkg::pad_keys_t          cont3_key,
  input  media_pkg::pad_keys_t          cont4_key,

  // video from the core
  input  logic                          h_blank,
  input  logic                          v_blank,
  input  logic                          core_hs,
  input  logic                          core_vs,
  input  media_pkg::rgb_t               core_rgb,

  // settings to the core
  output logic                          hide_overscan,
  output settings_pkg::edge_mask_t      mask_vid_edges,
  output logic                          allow_extra_sprites,
  output settings_pkg::palette_sel_t    selected_palette,
  output logic                          multitap_enabled,
  output logic                          external_reset,
  output logic                          ioctl_download,

  // data table
  output settings_pkg::datatable_addr_t datatable_addr,
  output logic                          datatable_wren,
  output settings_pkg::bridge_data_t    datatable_data,

  // pad words
  output media_pkg::console_pad_t       pad1,
  output media_pkg::console_pad_t       pad2,
  output media_pkg::console_pad_t       pad3,
  output media_pkg::console_pad_t       pad4,

  // scaler video
  output logic                          video_de,
  output logic                          video_hs,
  output logic                          video_vs,
  output media_pkg::rgb_t               video_rgb
);

  logic pad_swap;

  bridge_regs bridge_regs_i (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .bridge_addr           (bridge_addr),
    .bridge_wr             (bridge_wr),
    .bridge_wr_data        (bridge_wr_data),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .has_save              (has_save),
    .hide_overscan         (hide_overscan),
    .mask_vid_edges        (mask_vid_edges),
    .allow_extra_sprites   (allow_extra_sprites),
    .selected_palette      (selected_palette),
    .multitap_enabled      (multitap_enabled),
    .pad_swap              (pad_swap),
    .external_reset        (external_reset),
    .ioctl_download        (ioctl_download),
    .datatable_addr        (datatable_addr),
    .datatable_wren        (datatable_wren),
    .datatable_data        (datatable_data)
  );

  pad_mapper pad_mapper_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .pad_swap        (pad_swap),
    .cont1_key       (cont1_key),
    .cont2_key       (cont2_key),
    .cont3_key       (cont3_key),
    .cont4_key       (cont4_key),
    .pad1            (pad1),
    .pad2            (pad2),
    .pad3            (pad3),
    .pad4            (pad4)
  );

  video_conditioner video_conditioner_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .hide_overscan   (hide_overscan),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .core_hs         (core_hs),
    .core_vs         (core_vs),
    .core_rgb        (core_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

/* tests/tb_clock.sv */
//////////////////////////////
// clock and reset source for the testbench
// 100 ns clock, reset released on a falling edge
//////////////////////////////

`timescale 1ns/1ns

module tb_clock (
  output logic clk_74a,
  output logic pll_core_locked
);

  localparam int HALF_PERIOD = 50;
  localparam int RESET_LEN   = 10;

  initial clk_74a = 1'b0;

  always #HALF_PERIOD clk_74a = ~clk_74a;

  // hold reset for RESET_LEN cycles
  initial begin
    pll_core_locked = 1'b0;
    repeat (RESET_LEN) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;
  end

endmodule

/* tests/tb_top.sv */
//////////////////////////////
// testbench for nes_shell_top
// inputs change on the falling edge, outputs are sampled there too
// expected values come from the reference functions below
//////////////////////////////

`timescale 1ns/1ns

`include "core_cfg.svh"

module tb_top;

  import settings_pkg::*;
  import media_pkg::*;

  logic clk_74a;
  logic pll_core_locked;
  bridge_addr_t bridge_addr;
  logic bridge_wr;
  bridge_data_t bridge_wr_data;
  logic dataslot_requestwrite;
  logic dataslot_allcomplete;
  logic has_save;
  pad_keys_t cont1_key;
  pad_keys_t cont2_key;
  pad_keys_t cont3_key;
  pad_keys_t cont4_key;
  logic h_blank;
  logic v_blank;
  logic core_hs;
  logic core_vs;
  rgb_t core_rgb;
  logic hide_overscan;
  edge_mask_t mask_vid_edges;
  logic allow_extra_sprites;
  palette_sel_t selected_palette;
  logic multitap_enabled;
  logic external_reset;
  logic ioctl_download;
  datatable_addr_t datatable_addr;
  logic datatable_wren;
  bridge_data_t datatable_data;
  console_pad_t pad1;
  console_pad_t pad2;
  console_pad_t pad3;
  console_pad_t pad4;
  logic video_de;
  logic video_hs;
  logic video_vs;
  rgb_t video_rgb;

  int test_count;
  int check_count;
  int error_count;
  int error_mark;
  int wait_cycles;
  int high_cycles;
  logic [31:0] exp_setting [6];
  logic [15:0] key_bits [4];
  logic exp_download;
  logic exp_hide;
  bridge_addr_t reg_addr [6] = '{`ADDR_OVERSCAN, `ADDR_EDGE_MASK, `ADDR_EXTRA_SPRITES,
                                 `ADDR_PALETTE, `ADDR_MULTITAP, `ADDR_PAD_SWAP};
  bridge_addr_t unmapped_addr [4] = '{32'h0000_0054, 32'h0000_0201, 32'h0000_0400,
                                      32'h8000_0200};

  // video model state
  logic video_chk_on;
  logic chk_armed;
  logic cur_de;
  logic model_prev_de;
  logic exp_de;
  logic [23:0] exp_rgb;
  int slot_seen;

  tb_clock clock_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked)
  );

  nes_shell_top dut_i (.*);

  //////////////////////////////
  // reference functions
  //////////////////////////////

  // field width of each settings register
  function automatic logic [31:0] field_mask(input int idx);
    if (idx == 1) return 32'h3;
    if (idx == 3) return 32'h7;
    return 32'h1;
  endfunction

  function automatic logic [7:0] ref_pad(input logic [15:0] keys, input logic swap);
    logic [7:0] pad;
    pad[0]   = swap ? keys[5] : keys[4];
    pad[1]   = swap ? keys[7] : keys[5];
    pad[2]   = keys[14];
    pad[3]   = keys[15];
    pad[7:4] = keys[3:0];
    return pad;
  endfunction

  function automatic logic [23:0] ref_video_rgb(input logic de_now, input logic de_last,
                                                input logic hide, input logic [23:0] pix);
    logic [23:0] slot;
    slot = '0;
    slot[`SLOT_OVERSCAN_BIT] = hide;
    if (de_now) return pix;
    if (de_last) return slot;
    return '0;
  endfunction

  function automatic logic ref_download(input logic cur, input logic req, input logic done);
    if (req) return 1'b1;
    if (done) return 1'b0;
    return cur;
  endfunction

  function automatic logic [31:0] ref_save_word(input logic save);
    return save ? 32'(`SAVE_SIZE_BYTES) : 32'h0;
  endfunction

  //////////////////////////////
  // checks and bus tasks
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %s done, %0d errors", name, error_count - error_mark);
    error_mark = error_count;
  endtask

  // one write cycle, returns on the falling edge after the write edge
  task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr      = 1'b1;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic check_settings(input string name);
    check_value({name, " hide_overscan"}, exp_setting[0], 32'(hide_overscan));
    check_value({name, " mask_vid_edges"}, exp_setting[1], 32'(mask_vid_edges));
    check_value({name, " allow_extra_sprites"}, exp_setting[2], 32'(allow_extra_sprites));
    check_value({name, " selected_palette"}, exp_setting[3], 32'(selected_palette));
    check_value({name, " multitap_enabled"}, exp_setting[4], 32'(multitap_enabled));
  endtask

  task automatic run_pads(input logic swap);
    bus_write(`ADDR_PAD_SWAP, {31'($urandom), swap});
    for (int n = 0; n < 40; n++) begin
      for (int p = 0; p < 4; p++) key_bits[p] = 16'($urandom);
      cont1_key = key_bits[0];
      cont2_key = key_bits[1];
      cont3_key = key_bits[2];
      cont4_key = key_bits[3];
      @(negedge clk_74a);
      check_value("pad1", 32'(ref_pad(key_bits[0], swap)), 32'(pad1));
      check_value("pad2", 32'(ref_pad(key_bits[1], 1'b0)), 32'(pad2));
      check_value("pad3", 32'(ref_pad(key_bits[2], 1'b0)), 32'(pad3));
      check_value("pad4", 32'(ref_pad(key_bits[3], 1'b0)), 32'(pad4));
    end
  endtask

  task automatic run_video(input logic hide);
    bus_write(`ADDR_OVERSCAN, {31'($urandom), hide});
    exp_hide     = hide;
    exp_setting[0] = 32'(hide);
    video_chk_on = 1'b1;
    for (int n = 0; n < 300; n++) begin
      h_blank  = ($urandom_range(2, 0) == 0);
      v_blank  = ($urandom_range(7, 0) == 0);
      core_rgb = 24'($urandom);
      @(negedge clk_74a);
    end
    h_blank      = 1'b1;
    v_blank      = 1'b1;
    video_chk_on = 1'b0;
    repeat (2) @(negedge clk_74a);
  endtask

  // hold one sync high and find its single output pulse
  task automatic sync_pulse(input string name, input logic is_vs, input int latency);
    int pulses;
    int seen_at;
    pulses  = 0;
    seen_at = 0;
    if (is_vs) core_vs = 1'b1;
    else core_hs = 1'b1;
    for (int k = 1; k <= 20; k++) begin
      @(negedge clk_74a);
      if (is_vs ? video_vs : video_hs) begin
        pulses++;
        seen_at = k;
      end
    end
    core_vs = 1'b0;
    core_hs = 1'b0;
    check_value({name, " pulse count"}, 32'd1, 32'(pulses));
    check_value({name, " pulse latency"}, 32'(latency), 32'(seen_at));
  endtask

  task automatic slot_strobe(input logic req, input logic done);
    dataslot_requestwrite = req;
    dataslot_allcomplete  = done;
    @(negedge clk_74a);
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    exp_download = ref_download(exp_download, req, done);
    check_value("ioctl_download", 32'(exp_download), 32'(ioctl_download));
  endtask

  //////////////////////////////
  // video model and compare
  //////////////////////////////

  always @(posedge clk_74a) begin
    if (!pll_core_locked) begin
      model_prev_de = 1'b0;
      exp_de        = 1'b0;
      exp_rgb       = '0;
      chk_armed     = 1'b0;
    end else begin
      cur_de  = !(h_blank || v_blank);
      exp_de  = cur_de;
      exp_rgb = ref_video_rgb(cur_de, model_prev_de, exp_hide, core_rgb);
      if (video_chk_on && !cur_de && model_prev_de) slot_seen++;
      model_prev_de = cur_de;
      chk_armed     = video_chk_on;
    end
  end

  always @(negedge clk_74a) begin
    if (chk_armed) begin
      check_value("video_de", 32'(exp_de), 32'(video_de));
      check_value("video_rgb", 32'(exp_rgb), 32'(video_rgb));
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    void'($urandom(32'h071f_5fd9));
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    has_save = 1'b0;
    cont1_key = '0;
    cont2_key = '0;
    cont3_key = '0;
    cont4_key = '0;
    h_blank = 1'b1;
    v_blank = 1'b1;
    core_hs = 1'b0;
    core_vs = 1'b0;
    core_rgb = '0;
    exp_hide = 1'b0;
    exp_download = 1'b0;
    video_chk_on = 1'b0;
    slot_seen = 0;
    test_count = 0;
    check_count = 0;
    error_count = 0;
    error_mark = 0;
    for (int i = 0; i < 6; i++) exp_setting[i] = '0;

    wait_cycles = 0;
    while (!pll_core_locked && wait_cycles < 50) begin
      @(negedge clk_74a);
      wait_cycles++;
    end

    if (!pll_core_locked) begin
      $display("reset was never released within %0d cycles", wait_cycles);
      $display("TEST FAIL");
    end else begin
      @(negedge clk_74a);

      // settings registers, mapped and unmapped writes
      for (int round = 0; round < 3; round++) begin
        for (int idx = 0; idx < 6; idx++) begin
          bus_write(reg_addr[idx], bridge_data_t'($urandom));
          exp_setting[idx] = bridge_wr_data & field_mask(idx);
          check_settings("settings");
        end
      end
      for (int u = 0; u < 4; u++) begin
        bus_write(unmapped_addr[u], bridge_data_t'($urandom));
        check_settings("unmapped");
      end
      finish_test("settings");

      // soft reset length
      check_value("external_reset idle", 32'd0, 32'(external_reset));
      bus_write(`ADDR_RESET, bridge_data_t'($urandom));
      high_cycles = 0;
      while (external_reset && high_cycles < `RESET_CYCLES + 16) begin
        high_cycles++;
        @(negedge clk_74a);
      end
      if (external_reset) begin
        error_count++;
        $display("external_reset still high after %0d cycles", high_cycles);
      end
      check_value("external_reset length", 32'(`RESET_CYCLES), 32'(high_cycles));
      finish_test("soft_reset");

      run_pads(1'b0);
      run_pads(1'b1);
      finish_test("pads");

      run_video(1'b0);
      run_video(1'b1);
      if (slot_seen == 0) begin
        error_count++;
        $display("video stimulus never ended an active line");
      end
      finish_test("video");

      // vs follows its rise by one cycle, hs by the delay count
      sync_pulse("video_vs", 1'b1, 1);
      repeat (2) @(negedge clk_74a);
      sync_pulse("video_hs", 1'b0, `HS_DELAY_CYCLES);
      finish_test("syncs");

      // download level and data table
      slot_strobe(1'b1, 1'b0);
      for (int n = 0; n < 3; n++) slot_strobe(1'b0, 1'b0);
      slot_strobe(1'b0, 1'b1);
      slot_strobe(1'b1, 1'b1);
      slot_strobe(1'b0, 1'b1);
      check_value("datatable_wren", 32'd1, 32'(datatable_wren));
      check_value("datatable_addr", 32'(`DATATABLE_SAVE_ADDR), 32'(datatable_addr));
      check_value("datatable_data", ref_save_word(1'b0), datatable_data);
      has_save = 1'b1;
      @(negedge clk_74a);
      check_value("datatable_data", ref_save_word(1'b1), datatable_data);
      has_save = 1'b0;
      @(negedge clk_74a);
      check_value("datatable_data", ref_save_word(1'b0), datatable_data);
      check_value("datatable_wren", 32'd1, 32'(datatable_wren));
      finish_test("dataslot");

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hw
hw/settings_pkg.sv
hw/media_pkg.sv
hw/bridge_regs.sv
hw/pad_mapper.sv
hw/video_conditioner.sv
hw/nes_shell_top.sv
tests/tb_clock.sv
tests/tb_top.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: run clean

obj_dir/Vtb_top: tb.f $(SRCS)
	verilator --binary -f tb.f --top-module tb_top -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
